// ==== src/core_pkg.sv ====
package core_pkg;

  localparam int xlen = 32;
  localparam int arch_regs = 32;
  localparam int phys_regs = 64;
  localparam int window_depth = 8;
  localparam int rob_depth = 16;

  typedef logic [$clog2(arch_regs)-1:0] areg_t;
  typedef logic [$clog2(phys_regs)-1:0] preg_t;
  typedef logic [$clog2(rob_depth)-1:0] rob_tag_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_t;

  // MIPS major opcodes
  localparam logic [5:0] opc_rtype = 6'h00;
  localparam logic [5:0] opc_addi = 6'h08;
  localparam logic [5:0] opc_andi = 6'h0c;
  localparam logic [5:0] opc_ori = 6'h0d;
  localparam logic [5:0] opc_xori = 6'h0e;

  // R-type funct field
  localparam logic [5:0] fn_add = 6'h20;
  localparam logic [5:0] fn_sub = 6'h22;
  localparam logic [5:0] fn_and = 6'h24;
  localparam logic [5:0] fn_or = 6'h25;
  localparam logic [5:0] fn_xor = 6'h26;
  localparam logic [5:0] fn_slt = 6'h2a;

endpackage

// ==== src/fetch_unit.sv ====
module fetch_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      inst_mem_ready,
  input  logic [core_pkg::xlen-1:0] inst_in,
  input  logic                      id_ready,
  output logic [core_pkg::xlen-1:0] inst_address,
  output logic                      inst_mem_read,
  output logic                      if_valid,
  output logic [core_pkg::xlen-1:0] if_inst
);
  import core_pkg::*;

  logic pending;
  logic issue;

  // One request in flight, so the holding register is free when the word lands
  assign issue = !pending && (!if_valid || id_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      inst_address <= '0;
      inst_mem_read <= 1'b0;
      pending <= 1'b0;
      if_valid <= 1'b0;
    end else begin
      inst_mem_read <= issue;
      if (inst_mem_ready) begin
        pending <= 1'b0;
        inst_address <= inst_address + xlen'(4);
      end else if (issue) begin
        pending <= 1'b1;
      end
      if (inst_mem_ready) begin
        if_valid <= 1'b1;
      end else if (id_ready) begin
        if_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (inst_mem_ready) begin
      if_inst <= inst_in;
    end
  end

endmodule

// ==== src/inst_decoder.sv ====
module inst_decoder (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      if_valid,
  input  logic [core_pkg::xlen-1:0] if_inst,
  input  logic                      rn_stall,
  output logic                      id_ready,
  output logic                      id_valid,
  output core_pkg::alu_op_t         id_op,
  output logic                      id_use_imm,
  output logic [core_pkg::xlen-1:0] id_imm,
  output core_pkg::areg_t           id_src1,
  output core_pkg::areg_t           id_src2,
  output core_pkg::areg_t           id_rdst
);
  import core_pkg::*;

  logic [5:0] opcode;
  logic [5:0] funct;
  logic dec_valid;
  alu_op_t dec_op;
  logic dec_use_imm;
  logic [xlen-1:0] dec_imm;
  areg_t dec_rdst;

  assign opcode = if_inst[31:26];
  assign funct = if_inst[5:0];
  assign id_ready = !id_valid || !rn_stall;

  always_comb begin
    dec_valid = 1'b1;
    dec_op = alu_add;
    dec_use_imm = 1'b1;
    dec_imm = {{(xlen-16){1'b0}}, if_inst[15:0]};
    dec_rdst = if_inst[20:16];
    case (opcode)
      opc_rtype: begin
        dec_use_imm = 1'b0;
        dec_rdst = if_inst[15:11];
        case (funct)
          fn_add: dec_op = alu_add;
          fn_sub: dec_op = alu_sub;
          fn_and: dec_op = alu_and;
          fn_or: dec_op = alu_or;
          fn_xor: dec_op = alu_xor;
          fn_slt: dec_op = alu_slt;
          default: dec_valid = 1'b0;
        endcase
      end
      opc_addi: dec_imm = {{(xlen-16){if_inst[15]}}, if_inst[15:0]};
      opc_andi: dec_op = alu_and;
      opc_ori: dec_op = alu_or;
      opc_xori: dec_op = alu_xor;
      default: dec_valid = 1'b0;
    endcase
    // r0 writes are dropped as bubbles
    if (dec_rdst == '0) begin
      dec_valid = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid <= 1'b0;
    end else if (id_ready) begin
      id_valid <= if_valid && dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid && id_ready) begin
      id_op <= dec_op;
      id_use_imm <= dec_use_imm;
      id_imm <= dec_imm;
      id_src1 <= if_inst[25:21];
      id_src2 <= if_inst[20:16];
      id_rdst <= dec_rdst;
    end
  end

endmodule

// ==== src/register_rename.sv ====
module register_rename (
  input  logic             clk,
  input  logic             rst,
  input  logic             id_valid,
  input  core_pkg::areg_t  id_src1,
  input  core_pkg::areg_t  id_src2,
  input  core_pkg::areg_t  id_rdst,
  input  logic             id_use_imm,
  input  logic             window_full,
  input  logic             rob_full,
  input  core_pkg::preg_t  free_phy,
  input  logic             commit,
  input  logic             wb0_valid,
  input  core_pkg::preg_t  wb0_phy,
  input  logic             wb1_valid,
  input  core_pkg::preg_t  wb1_phy,
  output logic             rn_stall,
  output logic             rn_alloc,
  output core_pkg::preg_t  rn_psrc1,
  output core_pkg::preg_t  rn_psrc2,
  output logic             rn_src1_ready,
  output logic             rn_src2_ready,
  output core_pkg::preg_t  rn_pdst,
  output core_pkg::preg_t  rn_old_phy
);
  import core_pkg::*;

  typedef logic [$clog2(phys_regs-arch_regs)-1:0] fl_ptr_t;
  typedef logic [$clog2(phys_regs-arch_regs):0] fl_cnt_t;

  preg_t map_table [arch_regs];
  preg_t free_list [phys_regs-arch_regs];
  fl_ptr_t fl_head;
  fl_ptr_t fl_tail;
  fl_cnt_t fl_count;
  logic [phys_regs-1:0] busy;

  // Result on a writeback bus this cycle counts as ready
  function automatic logic wb_hit(preg_t p);
    return (wb0_valid && p == wb0_phy) || (wb1_valid && p == wb1_phy);
  endfunction

  assign rn_stall = (fl_count == '0) || rob_full || window_full;
  assign rn_alloc = id_valid && !rn_stall;
  assign rn_psrc1 = map_table[id_src1];
  assign rn_psrc2 = map_table[id_src2];
  assign rn_src1_ready = !busy[rn_psrc1] || wb_hit(rn_psrc1);
  assign rn_src2_ready = id_use_imm || !busy[rn_psrc2] || wb_hit(rn_psrc2);
  assign rn_pdst = free_list[fl_head];
  assign rn_old_phy = map_table[id_rdst];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < arch_regs; i++) begin
        map_table[i] <= preg_t'(i);
      end
      for (int i = 0; i < phys_regs - arch_regs; i++) begin
        free_list[i] <= preg_t'(arch_regs + i);
      end
      fl_head <= '0;
      fl_tail <= '0;
      fl_count <= fl_cnt_t'(phys_regs - arch_regs);
      busy <= '0;
    end else begin
      if (wb0_valid) begin
        busy[wb0_phy] <= 1'b0;
      end
      if (wb1_valid) begin
        busy[wb1_phy] <= 1'b0;
      end
      if (rn_alloc) begin
        map_table[id_rdst] <= rn_pdst;
        busy[rn_pdst] <= 1'b1;
        fl_head <= fl_head + 1'b1;
      end
      // Retired instruction returns its previous mapping
      if (commit) begin
        free_list[fl_tail] <= free_phy;
        fl_tail <= fl_tail + 1'b1;
      end
      fl_count <= fl_count + fl_cnt_t'(commit) - fl_cnt_t'(rn_alloc);
    end
  end

endmodule

// ==== src/issue_window.sv ====
module issue_window (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      rn_alloc,
  input  core_pkg::alu_op_t         rn_op,
  input  logic                      rn_use_imm,
  input  logic [core_pkg::xlen-1:0] rn_imm,
  input  core_pkg::preg_t           rn_psrc1,
  input  core_pkg::preg_t           rn_psrc2,
  input  logic                      rn_src1_ready,
  input  logic                      rn_src2_ready,
  input  core_pkg::preg_t           rn_pdst,
  input  core_pkg::rob_tag_t        rn_tag,
  input  logic                      wb0_valid,
  input  core_pkg::preg_t           wb0_phy,
  input  logic                      wb1_valid,
  input  core_pkg::preg_t           wb1_phy,
  output logic                      window_full,
  output logic                      sel0_en,
  output core_pkg::preg_t           sel0_src1,
  output core_pkg::preg_t           sel0_src2,
  output core_pkg::alu_op_t         sel0_op,
  output logic                      sel0_use_imm,
  output logic [core_pkg::xlen-1:0] sel0_imm,
  output core_pkg::preg_t           sel0_pdst,
  output core_pkg::rob_tag_t        sel0_tag,
  output logic                      sel1_en,
  output core_pkg::preg_t           sel1_src1,
  output core_pkg::preg_t           sel1_src2,
  output core_pkg::alu_op_t         sel1_op,
  output logic                      sel1_use_imm,
  output logic [core_pkg::xlen-1:0] sel1_imm,
  output core_pkg::preg_t           sel1_pdst,
  output core_pkg::rob_tag_t        sel1_tag
);
  import core_pkg::*;

  logic [window_depth-1:0] valid;
  logic [window_depth-1:0] rdy1;
  logic [window_depth-1:0] rdy2;
  logic [window_depth-1:0] use_imm_q;
  // elder[i] marks the entries inserted before entry i
  logic [window_depth-1:0] elder [window_depth];
  alu_op_t op_q [window_depth];
  logic [xlen-1:0] imm_q [window_depth];
  preg_t src1_q [window_depth];
  preg_t src2_q [window_depth];
  preg_t pdst_q [window_depth];
  rob_tag_t tag_q [window_depth];

  logic [window_depth-1:0] ready;
  logic [window_depth-1:0] ready1;
  logic [window_depth-1:0] pick0;
  logic [window_depth-1:0] pick1;
  logic [$clog2(window_depth)-1:0] ins_idx;
  logic [$clog2(window_depth)-1:0] idx0;
  logic [$clog2(window_depth)-1:0] idx1;

  function automatic logic wb_hit(preg_t p);
    return (wb0_valid && p == wb0_phy) || (wb1_valid && p == wb1_phy);
  endfunction

  assign window_full = &valid;
  assign ready = valid & rdy1 & (rdy2 | use_imm_q);
  assign ready1 = ready & ~pick0;

  always_comb begin
    ins_idx = '0;
    idx0 = '0;
    idx1 = '0;
    for (int i = window_depth - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        ins_idx = i[$clog2(window_depth)-1:0];
      end
    end
    // Oldest ready entry first, then the oldest of the rest
    for (int i = 0; i < window_depth; i++) begin
      pick0[i] = ready[i] && !(|(ready & elder[i]));
      pick1[i] = ready1[i] && !(|(ready1 & elder[i]));
      if (pick0[i]) begin
        idx0 = i[$clog2(window_depth)-1:0];
      end
      if (pick1[i]) begin
        idx1 = i[$clog2(window_depth)-1:0];
      end
    end
  end

  assign sel0_en = |pick0;
  assign sel0_src1 = src1_q[idx0];
  assign sel0_src2 = src2_q[idx0];
  assign sel0_op = op_q[idx0];
  assign sel0_use_imm = use_imm_q[idx0];
  assign sel0_imm = imm_q[idx0];
  assign sel0_pdst = pdst_q[idx0];
  assign sel0_tag = tag_q[idx0];
  assign sel1_en = |pick1;
  assign sel1_src1 = src1_q[idx1];
  assign sel1_src2 = src2_q[idx1];
  assign sel1_op = op_q[idx1];
  assign sel1_use_imm = use_imm_q[idx1];
  assign sel1_imm = imm_q[idx1];
  assign sel1_pdst = pdst_q[idx1];
  assign sel1_tag = tag_q[idx1];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else begin
      valid <= (valid & ~(pick0 | pick1)) | (window_depth'(rn_alloc) << ins_idx);
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < window_depth; i++) begin
      if (wb_hit(src1_q[i])) begin
        rdy1[i] <= 1'b1;
      end
      if (wb_hit(src2_q[i])) begin
        rdy2[i] <= 1'b1;
      end
    end
    if (rn_alloc) begin
      for (int i = 0; i < window_depth; i++) begin
        elder[i][ins_idx] <= 1'b0;
      end
      elder[ins_idx] <= valid;
      op_q[ins_idx] <= rn_op;
      use_imm_q[ins_idx] <= rn_use_imm;
      imm_q[ins_idx] <= rn_imm;
      src1_q[ins_idx] <= rn_psrc1;
      src2_q[ins_idx] <= rn_psrc2;
      rdy1[ins_idx] <= rn_src1_ready;
      rdy2[ins_idx] <= rn_src2_ready;
      pdst_q[ins_idx] <= rn_pdst;
      tag_q[ins_idx] <= rn_tag;
    end
  end

endmodule

// ==== src/phys_regfile.sv ====
module phys_regfile (
  input  logic                      clk,
  input  logic                      rst,
  input  core_pkg::preg_t           raddr0,
  input  core_pkg::preg_t           raddr1,
  input  core_pkg::preg_t           raddr2,
  input  core_pkg::preg_t           raddr3,
  output logic [core_pkg::xlen-1:0] rdata0,
  output logic [core_pkg::xlen-1:0] rdata1,
  output logic [core_pkg::xlen-1:0] rdata2,
  output logic [core_pkg::xlen-1:0] rdata3,
  input  logic                      we0,
  input  core_pkg::preg_t           waddr0,
  input  logic [core_pkg::xlen-1:0] wdata0,
  input  logic                      we1,
  input  core_pkg::preg_t           waddr1,
  input  logic [core_pkg::xlen-1:0] wdata1
);
  import core_pkg::*;

  logic [xlen-1:0] regs [phys_regs];

  assign rdata0 = regs[raddr0];
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];
  assign rdata3 = regs[raddr3];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < phys_regs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // Renaming keeps the two write addresses distinct
      if (we0) begin
        regs[waddr0] <= wdata0;
      end
      if (we1) begin
        regs[waddr1] <= wdata1;
      end
    end
  end

endmodule

// ==== src/ex_alu.sv ====
module ex_alu (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      sel_en,
  input  core_pkg::alu_op_t         op,
  input  logic                      use_imm,
  input  logic [core_pkg::xlen-1:0] imm,
  input  logic [core_pkg::xlen-1:0] src1,
  input  logic [core_pkg::xlen-1:0] src2,
  input  core_pkg::preg_t           pdst,
  input  core_pkg::rob_tag_t        tag,
  output logic                      wb_valid,
  output core_pkg::preg_t           wb_phy,
  output core_pkg::rob_tag_t        wb_tag,
  output logic [core_pkg::xlen-1:0] wb_result
);
  import core_pkg::*;

  logic [xlen-1:0] opb;
  logic [xlen-1:0] result;

  assign opb = use_imm ? imm : src2;

  always_comb begin
    case (op)
      alu_add: result = src1 + opb;
      alu_sub: result = src1 - opb;
      alu_and: result = src1 & opb;
      alu_or: result = src1 | opb;
      alu_xor: result = src1 ^ opb;
      alu_slt: result = {{(xlen-1){1'b0}}, $signed(src1) < $signed(opb)};
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= sel_en;
    end
  end

  always_ff @(posedge clk) begin
    if (sel_en) begin
      wb_phy <= pdst;
      wb_tag <= tag;
      wb_result <= result;
    end
  end

endmodule

// ==== src/commit_unit.sv ====
module commit_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      rn_alloc,
  input  core_pkg::areg_t           rn_rdst,
  input  core_pkg::preg_t           rn_old_phy,
  input  logic                      wb0_valid,
  input  core_pkg::rob_tag_t        wb0_tag,
  input  logic [core_pkg::xlen-1:0] wb0_result,
  input  logic                      wb1_valid,
  input  core_pkg::rob_tag_t        wb1_tag,
  input  logic [core_pkg::xlen-1:0] wb1_result,
  output core_pkg::rob_tag_t        rob_tail,
  output logic                      rob_full,
  output logic                      commit,
  output core_pkg::areg_t           commit_rdst,
  output logic [core_pkg::xlen-1:0] commit_result,
  output core_pkg::preg_t           free_phy
);
  import core_pkg::*;

  typedef logic [$clog2(rob_depth):0] rob_cnt_t;

  logic [rob_depth-1:0] done;
  areg_t rdst_q [rob_depth];
  preg_t old_q [rob_depth];
  logic [xlen-1:0] result_q [rob_depth];
  rob_tag_t head;
  rob_tag_t tail;
  rob_cnt_t count;

  assign rob_tail = tail;
  assign rob_full = count == rob_cnt_t'(rob_depth);
  // Done bits clear on retire, so an empty buffer never commits
  assign commit = done[head];
  assign commit_rdst = rdst_q[head];
  assign commit_result = result_q[head];
  assign free_phy = old_q[head];

  always_ff @(posedge clk) begin
    if (rst) begin
      done <= '0;
      head <= '0;
      tail <= '0;
      count <= '0;
    end else begin
      if (rn_alloc) begin
        done[tail] <= 1'b0;
        tail <= tail + 1'b1;
      end
      if (wb0_valid) begin
        done[wb0_tag] <= 1'b1;
      end
      if (wb1_valid) begin
        done[wb1_tag] <= 1'b1;
      end
      if (commit) begin
        done[head] <= 1'b0;
        head <= head + 1'b1;
      end
      count <= count + rob_cnt_t'(rn_alloc) - rob_cnt_t'(commit);
    end
  end

  always_ff @(posedge clk) begin
    if (rn_alloc) begin
      rdst_q[tail] <= rn_rdst;
      old_q[tail] <= rn_old_phy;
    end
    if (wb0_valid) begin
      result_q[wb0_tag] <= wb0_result;
    end
    if (wb1_valid) begin
      result_q[wb1_tag] <= wb1_result;
    end
  end

endmodule

// ==== src/processor.sv ====
module processor (
  input  logic                      clk,
  input  logic                      rst,
  output logic [core_pkg::xlen-1:0] inst_address,
  input  logic [core_pkg::xlen-1:0] inst_in,
  input  logic                      inst_mem_ready,
  output logic                      inst_mem_read,
  output logic                      commit,
  output core_pkg::areg_t           commit_rdst,
  output logic [core_pkg::xlen-1:0] commit_result
);
  import core_pkg::*;

  logic if_valid;
  logic [xlen-1:0] if_inst;
  logic id_ready;
  logic id_valid;
  alu_op_t id_op;
  logic id_use_imm;
  logic [xlen-1:0] id_imm;
  areg_t id_src1;
  areg_t id_src2;
  areg_t id_rdst;

  logic rn_stall;
  logic rn_alloc;
  preg_t rn_psrc1;
  preg_t rn_psrc2;
  logic rn_src1_ready;
  logic rn_src2_ready;
  preg_t rn_pdst;
  preg_t rn_old_phy;

  logic window_full;
  logic sel0_en;
  logic sel1_en;
  preg_t sel0_src1;
  preg_t sel0_src2;
  preg_t sel1_src1;
  preg_t sel1_src2;
  alu_op_t sel0_op;
  alu_op_t sel1_op;
  logic sel0_use_imm;
  logic sel1_use_imm;
  logic [xlen-1:0] sel0_imm;
  logic [xlen-1:0] sel1_imm;
  preg_t sel0_pdst;
  preg_t sel1_pdst;
  rob_tag_t sel0_tag;
  rob_tag_t sel1_tag;

  // Operands read in the select cycle
  logic [xlen-1:0] alu0_src1;
  logic [xlen-1:0] alu0_src2;
  logic [xlen-1:0] alu1_src1;
  logic [xlen-1:0] alu1_src2;

  logic wb0_valid;
  logic wb1_valid;
  preg_t wb0_phy;
  preg_t wb1_phy;
  rob_tag_t wb0_tag;
  rob_tag_t wb1_tag;
  logic [xlen-1:0] wb0_result;
  logic [xlen-1:0] wb1_result;

  rob_tag_t rob_tail;
  logic rob_full;
  preg_t free_phy;

  fetch_unit fetch_unit (.*);

  inst_decoder inst_decoder (.*);

  register_rename register_rename (.*);

  issue_window issue_window (
    .rn_op(id_op),
    .rn_use_imm(id_use_imm),
    .rn_imm(id_imm),
    .rn_tag(rob_tail),
    .*
  );

  phys_regfile phys_regfile (
    .clk(clk),
    .rst(rst),
    .raddr0(sel0_src1),
    .raddr1(sel0_src2),
    .raddr2(sel1_src1),
    .raddr3(sel1_src2),
    .rdata0(alu0_src1),
    .rdata1(alu0_src2),
    .rdata2(alu1_src1),
    .rdata3(alu1_src2),
    .we0(wb0_valid),
    .waddr0(wb0_phy),
    .wdata0(wb0_result),
    .we1(wb1_valid),
    .waddr1(wb1_phy),
    .wdata1(wb1_result)
  );

  ex_alu alu0 (
    .clk(clk),
    .rst(rst),
    .sel_en(sel0_en),
    .op(sel0_op),
    .use_imm(sel0_use_imm),
    .imm(sel0_imm),
    .src1(alu0_src1),
    .src2(alu0_src2),
    .pdst(sel0_pdst),
    .tag(sel0_tag),
    .wb_valid(wb0_valid),
    .wb_phy(wb0_phy),
    .wb_tag(wb0_tag),
    .wb_result(wb0_result)
  );

  ex_alu alu1 (
    .clk(clk),
    .rst(rst),
    .sel_en(sel1_en),
    .op(sel1_op),
    .use_imm(sel1_use_imm),
    .imm(sel1_imm),
    .src1(alu1_src1),
    .src2(alu1_src2),
    .pdst(sel1_pdst),
    .tag(sel1_tag),
    .wb_valid(wb1_valid),
    .wb_phy(wb1_phy),
    .wb_tag(wb1_tag),
    .wb_result(wb1_result)
  );

  commit_unit commit_unit (
    .rn_rdst(id_rdst),
    .*
  );

endmodule

// ==== tb/processor_assert.sv ====
module processor_assert (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [core_pkg::xlen-1:0] inst_address,
  input  logic [core_pkg::xlen-1:0] inst_in,
  input  logic                      inst_mem_ready,
  input  logic                      inst_mem_read,
  input  logic                      commit,
  input  core_pkg::areg_t           commit_rdst,
  input  logic [core_pkg::xlen-1:0] commit_result
);
  import core_pkg::*;

  logic [xlen-1:0] arch [arch_regs];
  // Expected retirements in program order
  areg_t exp_rdst [256];
  logic [xlen-1:0] exp_result [256];
  int wr_ptr;
  int rd_ptr;
  int pending;
  int words_seen;
  int error_count = 0;
  logic seen_read;
  logic outstanding;
  logic [xlen-1:0] last_addr;

  assign pending = wr_ptr - rd_ptr;

  always @(posedge clk) begin
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] r;
    logic [xlen-1:0] sext;
    logic [xlen-1:0] zext;
    areg_t rd;
    logic ok;
    if (rst) begin
      for (int i = 0; i < arch_regs; i++) begin
        arch[i] <= '0;
      end
      wr_ptr <= 0;
      rd_ptr <= 0;
      words_seen <= 0;
      seen_read <= 1'b0;
      outstanding <= 1'b0;
      last_addr <= '0;
    end else begin
      if (inst_mem_read) begin
        seen_read <= 1'b1;
        outstanding <= 1'b1;
        last_addr <= inst_address;
      end else if (inst_mem_ready) begin
        outstanding <= 1'b0;
      end
      if (inst_mem_ready) begin
        words_seen <= words_seen + 1;
        a = arch[inst_in[25:21]];
        b = arch[inst_in[20:16]];
        sext = {{16{inst_in[15]}}, inst_in[15:0]};
        zext = {16'h0000, inst_in[15:0]};
        rd = inst_in[20:16];
        r = '0;
        ok = 1'b1;
        case (inst_in[31:26])
          opc_rtype: begin
            rd = inst_in[15:11];
            case (inst_in[5:0])
              fn_add: r = a + b;
              fn_sub: r = a - b;
              fn_and: r = a & b;
              fn_or: r = a | b;
              fn_xor: r = a ^ b;
              fn_slt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
              default: ok = 1'b0;
            endcase
          end
          opc_addi: r = a + sext;
          opc_andi: r = a & zext;
          opc_ori: r = a | zext;
          opc_xori: r = a ^ zext;
          default: ok = 1'b0;
        endcase
        if (rd == '0) begin
          ok = 1'b0;
        end
        if (ok) begin
          arch[rd] <= r;
          exp_rdst[wr_ptr[7:0]] <= rd;
          exp_result[wr_ptr[7:0]] <= r;
          wr_ptr <= wr_ptr + 1;
        end
      end
      if (commit) begin
        rd_ptr <= rd_ptr + 1;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk) rst |=> !inst_mem_read && !commit)
    else begin
      error_count = error_count + 1;
      $error("[ERROR] inst_mem_read 0x%h commit 0x%h near reset", $sampled(inst_mem_read),
             $sampled(commit));
    end

  a_first_addr: assert property (@(posedge clk) disable iff (rst)
      inst_mem_read && !seen_read |-> inst_address == '0)
    else begin
      error_count = error_count + 1;
      $error("[ERROR] inst_address 0x%h expected 0x0 on first read", $sampled(inst_address));
    end

  a_one_read: assert property (@(posedge clk) disable iff (rst)
      inst_mem_read |-> !outstanding)
    else begin
      error_count = error_count + 1;
      $error("[ERROR] inst_mem_read 0x%h while read at 0x%h pending", $sampled(inst_mem_read),
             $sampled(last_addr));
    end

  a_addr_step: assert property (@(posedge clk) disable iff (rst)
      inst_mem_read && seen_read |-> inst_address == last_addr + 32'd4)
    else begin
      error_count = error_count + 1;
      $error("[ERROR] inst_address 0x%h expected 0x%h", $sampled(inst_address),
             $sampled(last_addr) + 32'd4);
    end

  // Bubbles never retire
  a_commit_expected: assert property (@(posedge clk) disable iff (rst)
      commit |-> pending > 0)
    else begin
      error_count = error_count + 1;
      $error("[ERROR] commit with commit_rdst 0x%h and nothing expected",
             $sampled(commit_rdst));
    end

  a_commit_rdst: assert property (@(posedge clk) disable iff (rst)
      commit && pending > 0 |-> commit_rdst == exp_rdst[rd_ptr[7:0]])
    else begin
      error_count = error_count + 1;
      $error("[ERROR] commit_rdst 0x%h expected 0x%h", $sampled(commit_rdst),
             $sampled(exp_rdst[rd_ptr[7:0]]));
    end

  a_commit_result: assert property (@(posedge clk) disable iff (rst)
      commit && pending > 0 |-> commit_result == exp_result[rd_ptr[7:0]])
    else begin
      error_count = error_count + 1;
      $error("[ERROR] commit_result 0x%h expected 0x%h", $sampled(commit_result),
             $sampled(exp_result[rd_ptr[7:0]]));
    end

endmodule

// ==== tb/tb_processor.sv ====
module tb_processor;
  import core_pkg::*;

  localparam int prog_len = 200;
  localparam int cycle_limit = prog_len * 8 + 200;

  logic clk;
  logic rst;
  logic [xlen-1:0] inst_address;
  logic [xlen-1:0] inst_in;
  logic inst_mem_ready;
  logic inst_mem_read;
  logic commit;
  areg_t commit_rdst;
  logic [xlen-1:0] commit_result;

  logic [xlen-1:0] prog [prog_len];
  logic mem_busy;
  int mem_wait;
  logic [xlen-1:0] mem_addr;
  int cycles;
  int timeout_count;
  logic finished;

  processor dut0 (
    .clk(clk),
    .rst(rst),
    .inst_address(inst_address),
    .inst_in(inst_in),
    .inst_mem_ready(inst_mem_ready),
    .inst_mem_read(inst_mem_read),
    .commit(commit),
    .commit_rdst(commit_rdst),
    .commit_result(commit_result)
  );

  bind processor processor_assert chk (
    .clk(clk),
    .rst(rst),
    .inst_address(inst_address),
    .inst_in(inst_in),
    .inst_mem_ready(inst_mem_ready),
    .inst_mem_read(inst_mem_read),
    .commit(commit),
    .commit_rdst(commit_rdst),
    .commit_result(commit_result)
  );

  always #50 clk = ~clk;

  // Past the program the memory returns word 0
  function automatic logic [xlen-1:0] word_at(logic [xlen-1:0] addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < prog_len) begin
      return prog[idx];
    end
    return '0;
  endfunction

  function automatic logic [5:0] funct_for(int pick);
    case (pick)
      0: return fn_add;
      1: return fn_sub;
      2: return fn_and;
      3: return fn_or;
      4: return fn_xor;
      default: return fn_slt;
    endcase
  endfunction

  function automatic logic [5:0] opcode_for(int pick);
    case (pick)
      6: return opc_addi;
      7: return opc_andi;
      8: return opc_ori;
      default: return opc_xori;
    endcase
  endfunction

  task automatic build_program();
    int kind;
    int pick;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] last_rd;
    logic [15:0] imm;
    last_rd = 5'd1;
    for (int i = 0; i < prog_len; i++) begin
      kind = int'($urandom % 100);
      pick = int'($urandom % 10);
      // Half the sources lean on the last result for short chains
      rs = ($urandom % 2 == 0) ? last_rd : 5'($urandom % 16);
      rt = ($urandom % 2 == 0) ? last_rd : 5'($urandom % 16);
      rd = 5'(1 + $urandom % 15);
      imm = 16'($urandom);
      if (kind < 5) begin
        prog[i] = '0;
      end else if (kind < 10) begin
        prog[i] = {6'h3f, rs, rt, imm};
      end else if (pick < 6) begin
        prog[i] = {opc_rtype, rs, rt, rd, 5'd0, funct_for(pick)};
        last_rd = rd;
      end else begin
        prog[i] = {opcode_for(pick), rs, rd, imm};
        last_rd = rd;
      end
    end
  endtask

  // Instruction memory with 1 to 3 cycles of latency
  always @(posedge clk) begin
    int lat;
    if (rst) begin
      mem_busy <= 1'b0;
      mem_wait <= 0;
      inst_mem_ready <= 1'b0;
    end else begin
      inst_mem_ready <= 1'b0;
      if (inst_mem_read) begin
        lat = 1 + int'($urandom % 3);
        if (lat == 1) begin
          inst_mem_ready <= 1'b1;
          inst_in <= word_at(inst_address);
        end else begin
          mem_busy <= 1'b1;
          mem_wait <= lat - 2;
          mem_addr <= inst_address;
        end
      end else if (mem_busy) begin
        if (mem_wait == 0) begin
          inst_mem_ready <= 1'b1;
          inst_in <= word_at(mem_addr);
          mem_busy <= 1'b0;
        end else begin
          mem_wait <= mem_wait - 1;
        end
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    inst_in = '0;
    inst_mem_ready = 1'b0;
    mem_busy = 1'b0;
    mem_wait = 0;
    mem_addr = '0;
    cycles = 0;
    timeout_count = 0;
    finished = 1'b0;
    void'($urandom(32));
    build_program();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    while (cycles < cycle_limit && !finished) begin
      @(negedge clk);
      cycles = cycles + 1;
      finished = dut0.chk.words_seen >= prog_len && dut0.chk.pending == 0;
    end
    if (!finished) begin
      timeout_count = 1;
      $display("Timeout after %0d cycles with %0d retirements still expected",
               cycles, dut0.chk.pending);
    end
    repeat (2) @(posedge clk);
    $display("Errors: %0d assertion failures, %0d timeouts", dut0.chk.error_count,
             timeout_count);
    if (dut0.chk.error_count == 0 && timeout_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
src/core_pkg.sv
src/fetch_unit.sv
src/inst_decoder.sv
src/register_rename.sv
src/issue_window.sv
src/phys_regfile.sv
src/ex_alu.sv
src/commit_unit.sv
src/processor.sv
tb/processor_assert.sv
tb/tb_processor.sv

// ==== run.sh ====
#!/bin/bash
set -e
set -o pipefail

verilator --binary --timing --assert -Wno-fatal --top-module tb_processor \
  -f verilog.f -o sim_tb

./obj_dir/sim_tb +verilator+error+limit+100000 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
